// ==== verification/tcm_trace.txt ====
# op addr wdata mask stall err rdata chk bb  (all hex, op 1 = store)
# stall = cycles rsp_ready held low, chk 0 = rdata don't care, bb 1 = no idle gap before
0 80000100 00000000 0 0 0 00000000 0 0
1 80000010 11223344 f 0 0 00000000 1 0
1 90000010 a5a5a5a5 f 0 0 00000000 1 0
0 80000010 00000000 0 0 0 11223344 1 0
0 90000010 00000000 0 0 0 a5a5a5a5 1 0
1 80000024 cafef00d f 0 0 00000000 1 0
1 90000ffc deadbeef f 0 0 00000000 1 0
0 80000024 00000000 0 0 0 cafef00d 1 0
0 90000ffc 00000000 0 0 0 deadbeef 1 0
1 80000010 aabbccdd 1 0 0 00000000 1 0
0 80000010 00000000 0 0 0 112233dd 1 0
1 80000010 eeff0011 6 0 0 00000000 1 0
0 80000010 00000000 0 0 0 11ff00dd 1 0
1 90000010 5a5a5a5a 8 0 0 00000000 1 0
0 90000010 00000000 0 0 0 5aa5a5a5 1 0
1 90000010 ffffffff 0 0 0 00000000 1 0
0 90000010 00000000 0 0 0 5aa5a5a5 1 0
1 40000010 ffffffff f 0 1 00000000 1 0
0 a0000010 00000000 0 0 1 00000000 1 0
1 00000010 12345678 f 0 1 00000000 1 0
0 80000010 00000000 0 0 0 11ff00dd 1 0
0 90000010 00000000 0 0 0 5aa5a5a5 1 0
0 80000024 00000000 0 3 0 cafef00d 1 0
1 90000020 01020304 f 2 0 00000000 1 0
0 90000020 00000000 0 4 0 01020304 1 0
0 f0000000 00000000 0 2 1 00000000 1 0
1 80000040 00000040 f 0 0 00000000 1 0
1 80000044 00000044 f 0 0 00000000 1 1
1 90000040 10000040 f 0 0 00000000 1 1
0 80000040 00000000 0 0 0 00000040 1 1
0 80000044 00000000 0 0 0 00000044 1 1
0 90000040 00000000 0 0 0 10000040 1 1
0 50000000 00000000 0 0 1 00000000 1 1
1 90000044 0badcafe f 0 0 00000000 1 1
0 90000044 00000000 0 0 0 0badcafe 1 1
0 80000040 00000000 0 0 0 00000040 1 1

// ==== project.f ====
+incdir+include
src/tcm_bus_pkg.sv
src/tcm_map_pkg.sv
src/tcm_req_if.sv
src/tcm_sram.sv
src/tcm_bank_ctrl.sv
src/tcm_addr_decode.sv
src/tcm_top.sv
verification/tcm_asserts.sv
verification/tcm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the TCM testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tcm_tb -o tcm_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tcm_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no verdict"; exit 1; }
echo "PASS"

// ==== verification/tcm_tb.sv ====
// TCM subsystem testbench

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_tb;

    localparam int MAX_TXN  = 128;                   // trace capacity
    localparam int WAIT_MAX = 50;                    // cycles per handshake wait
    localparam int RUN_MAX  = 5000;                  // whole run, in cycles

    logic               clk;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    logic               req_we;
    logic [`TCM_AW-1:0] req_addr;
    logic [`TCM_DW-1:0] req_wdata;
    logic [`TCM_MW-1:0] req_wmask;
    logic               rsp_valid;
    logic               rsp_ready;
    logic               rsp_err;
    logic [`TCM_DW-1:0] rsp_rdata;

    // ============================================================
    // trace columns and scoreboard
    // ============================================================

    logic               t_we    [MAX_TXN];
    logic [`TCM_AW-1:0] t_addr  [MAX_TXN];
    logic [`TCM_DW-1:0] t_wdata [MAX_TXN];
    logic [`TCM_MW-1:0] t_wmask [MAX_TXN];
    int                 t_stall [MAX_TXN];           // cycles of rsp_ready low
    logic               t_err   [MAX_TXN];
    logic [`TCM_DW-1:0] t_rdata [MAX_TXN];
    logic               t_chk   [MAX_TXN];           // 0 means rdata don't care
    logic               t_bb    [MAX_TXN];           // no idle gap before this one
    int                 n_txn;

    int                 pend_q[$];                   // accepted, response not taken yet
    int                 next_idx;                    // next trace line to issue
    int                 gap_left;
    int                 stall_left;
    int                 req_wait;
    int                 rsp_wait;
    int                 cycle;
    logic               head_seen;                   // head response already compared
    logic               held_err;
    logic [`TCM_DW-1:0] held_rdata;                  // value a stalled response must keep
    logic               accepted;                    // request transfer on coming edge
    logic               taken;                       // response transfer on coming edge
    logic               timed_out;
    int                 val_errs;
    int                 misc_errs;

    tcm_top dut0 (.*);

    bind tcm_top tcm_asserts asserts0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wmask (req_wmask),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_err   (rsp_err),
        .rsp_rdata (rsp_rdata)
    );

    always #50 clk = ~clk;                           // 100 ns period

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("ERR %s at cycle %0d: expected %0h, got %0h", name, cycle, exp, act);
        val_errs++;
    endtask

    // comment lines start with #, all columns hex
    task automatic load_trace();
        int    fd;
        int    fields;
        string line;
        n_txn = 0;
        fd    = $fopen("verification/tcm_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verification/tcm_trace.txt");
            misc_errs++;
        end else begin
            while (!$feof(fd) && n_txn < MAX_TXN) begin
                line = "";
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 t_we[n_txn], t_addr[n_txn], t_wdata[n_txn],
                                 t_wmask[n_txn], t_stall[n_txn], t_err[n_txn],
                                 t_rdata[n_txn], t_chk[n_txn], t_bb[n_txn]);
                if (fields == 9) begin
                    n_txn++;
                end
            end
            $fclose(fd);
        end
        if (n_txn == 0) begin
            $display("the trace holds no transactions");
            misc_errs++;
        end
    endtask

    // ============================================================
    // mid-cycle sampling, inputs are stable here
    // ============================================================

    task automatic check_cycle();
        int   head;
        logic exp_ready;
        exp_ready = (pend_q.size() == 0) || rsp_ready;   // free, or freed on this edge
        accepted  = 1'b0;
        taken     = 1'b0;
        if (req_ready !== exp_ready) begin
            flag_mismatch("req_ready", 32'(exp_ready), 32'(req_ready));
        end
        if (pend_q.size() == 0) begin
            if (rsp_valid !== 1'b0) begin
                flag_mismatch("rsp_valid", 32'h0, 32'(rsp_valid));
            end
        end else if (rsp_valid !== 1'b1) begin
            if (rsp_wait == 0) begin                 // late response, report once
                flag_mismatch("rsp_valid", 32'h1, 32'(rsp_valid));
            end
            rsp_wait++;
            if (rsp_wait >= WAIT_MAX) begin
                $display("timeout: no response for transaction %0d", pend_q[0]);
                timed_out = 1'b1;
            end
        end else begin
            head     = pend_q[0];
            rsp_wait = 0;
            taken    = rsp_ready;
            if (!head_seen) begin
                head_seen  = 1'b1;
                held_err   = rsp_err;
                held_rdata = rsp_rdata;
                if (rsp_err !== t_err[head]) begin
                    flag_mismatch("rsp_err", 32'(t_err[head]), 32'(rsp_err));
                end
                if (t_chk[head] && rsp_rdata !== t_rdata[head]) begin
                    flag_mismatch("rsp_rdata", t_rdata[head], rsp_rdata);
                end
            end else begin
                if (rsp_err !== held_err) begin      // stalled, must not move
                    flag_mismatch("rsp_err", 32'(held_err), 32'(rsp_err));
                end
                if (rsp_rdata !== held_rdata) begin
                    flag_mismatch("rsp_rdata", held_rdata, rsp_rdata);
                end
            end
        end
        if (req_valid) begin
            if (req_ready === 1'b1) begin
                accepted = 1'b1;
                req_wait = 0;
            end else begin
                req_wait++;
                if (req_wait >= WAIT_MAX) begin
                    $display("timeout: transaction %0d never accepted", next_idx);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    // ============================================================
    // after the edge, update scoreboard and drive
    // ============================================================

    task automatic advance();
        if (taken) begin
            void'(pend_q.pop_front());
            head_seen = 1'b0;
        end
        if (accepted) begin
            pend_q.push_back(next_idx);
            stall_left = t_stall[next_idx];          // new head of the queue
            next_idx++;
            if (next_idx < n_txn) begin
                gap_left = t_bb[next_idx] ? 0 : int'($urandom % 32'd3);
            end
        end
        if (pend_q.size() != 0 && stall_left > 0) begin
            rsp_ready = 1'b0;                        // back-pressure
            stall_left--;
        end else begin
            rsp_ready = 1'b1;
        end
        if (accepted || !req_valid) begin
            if (next_idx < n_txn && gap_left == 0) begin
                req_valid = 1'b1;
                req_we    = t_we[next_idx];
                req_addr  = t_addr[next_idx];
                req_wdata = t_wdata[next_idx];
                req_wmask = t_wmask[next_idx];
            end else begin
                req_valid = 1'b0;
                if (gap_left > 0) begin
                    gap_left--;
                end
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wmask  = '0;
        rsp_ready  = 1'b1;
        next_idx   = 0;
        gap_left   = 0;
        stall_left = 0;
        req_wait   = 0;
        rsp_wait   = 0;
        cycle      = 0;
        head_seen  = 1'b0;
        accepted   = 1'b0;
        taken      = 1'b0;
        timed_out  = 1'b0;
        val_errs   = 0;
        misc_errs  = 0;
        void'($urandom(32'h54b2));                   // single seed for the run
        load_trace();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        while (n_txn > 0 && !timed_out && !(next_idx >= n_txn && pend_q.size() == 0)) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            cycle++;
            #1;
            if (!timed_out) begin
                advance();
            end
            if (cycle >= RUN_MAX) begin
                $display("timeout: run went past %0d cycles", RUN_MAX);
                timed_out = 1'b1;
            end
        end
        $display("errors: %0d value, %0d other, %0d timeout", val_errs, misc_errs, timed_out);
        if (val_errs == 0 && misc_errs == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tcm_asserts.sv ====
// TCM handshake assertions

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_asserts (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               req_valid,
    input wire logic               req_ready,
    input wire logic               req_we,
    input wire logic [`TCM_AW-1:0] req_addr,
    input wire logic [`TCM_DW-1:0] req_wdata,
    input wire logic [`TCM_MW-1:0] req_wmask,
    input wire logic               rsp_valid,
    input wire logic               rsp_ready,
    input wire logic               rsp_err,
    input wire logic [`TCM_DW-1:0] rsp_rdata
);

    // ============================================================
    // hold rules on both channels
    // ============================================================

    req_hold: assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=>
            (req_valid && $stable(req_we) && $stable(req_addr)
             && $stable(req_wdata) && $stable(req_wmask)))
        else $error("request dropped or changed before it was accepted");

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_err) && $stable(rsp_rdata)))
        else $error("response dropped or changed before it was taken");

    // ============================================================
    // timing
    // ============================================================

    rsp_latency: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_ready) |=> rsp_valid)             // one cycle, every outcome
        else $error("no response one cycle after acceptance");

    stall_only: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (req_ready == rsp_ready))             // req_ready low only on a stall
        else $error("req_ready does not track rsp_ready while a response is pending");

    reset_idle: assert property (@(posedge clk)
        rst |=> !rsp_valid)
        else $error("response valid after reset");

endmodule

`default_nettype wire

// ==== src/tcm_top.sv ====
// TCM subsystem top level

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_top (
    input  wire logic               clk,
    input  wire logic               rst,
    // request from core
    input  wire logic               req_valid,
    output logic                    req_ready,
    input  wire logic               req_we,          // 1 store, 0 load
    input  wire logic [`TCM_AW-1:0] req_addr,
    input  wire logic [`TCM_DW-1:0] req_wdata,
    input  wire logic [`TCM_MW-1:0] req_wmask,
    // response to core
    output logic                    rsp_valid,
    input  wire logic               rsp_ready,
    output logic                    rsp_err,
    output logic [`TCM_DW-1:0]      rsp_rdata
);

    import tcm_bus_pkg::*;

    tcm_req_t req_pkt;
    tcm_rsp_t rsp_pkt;

    // ============================================================
    // plain ports to bus structs
    // ============================================================

    assign req_pkt.kind  = req_we ? tcm_write : tcm_read;
    assign req_pkt.addr  = req_addr;
    assign req_pkt.wdata = req_wdata;
    assign req_pkt.wmask = req_wmask;

    assign rsp_err   = (rsp_pkt.status == tcm_error);
    assign rsp_rdata = rsp_pkt.rdata;

    tcm_req_if itcm_if ();                           // decoder to ITCM bank
    tcm_req_if dtcm_if ();                           // decoder to DTCM bank

    tcm_addr_decode decode0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req_pkt),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp_pkt),
        .itcm      (itcm_if.decoder),
        .dtcm      (dtcm_if.decoder)
    );

    tcm_bank_ctrl #(.DEPTH(`TCM_ITCM_DEPTH)) itcm0 (
        .clk (clk),
        .rst (rst),
        .bus (itcm_if.bank)
    );

    tcm_bank_ctrl #(.DEPTH(`TCM_DTCM_DEPTH)) dtcm0 (
        .clk (clk),
        .rst (rst),
        .bus (dtcm_if.bank)
    );

endmodule

`default_nettype wire

// ==== src/tcm_addr_decode.sv ====
// TCM address decoder and response mux

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_addr_decode (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire tcm_bus_pkg::tcm_req_t req,
    output logic                      rsp_valid,
    input  wire logic                 rsp_ready,
    output tcm_bus_pkg::tcm_rsp_t     rsp,
    tcm_req_if.decoder                itcm,
    tcm_req_if.decoder                dtcm
);

    import tcm_bus_pkg::*;
    import tcm_map_pkg::*;

    tcm_addr_u   addr_u;                             // request address, split view
    tcm_region_e sel;                                // target of the incoming request
    tcm_region_e owner_q;                            // source of the pending response
    logic        pend_q;                             // one response outstanding
    logic        slot_free;                          // room for a new request
    logic        sel_ready;
    logic        accept;
    logic        err_valid;                          // error slot holds a response

    // ============================================================
    // request routing
    // ============================================================

    assign addr_u.raw = req.addr;

    always_comb begin
        case (addr_u.fields.region)
            `TCM_ITCM_REGION: sel = region_itcm;
            `TCM_DTCM_REGION: sel = region_dtcm;
            default:          sel = region_none;     // unmapped, error path
        endcase
    end

    // one response in flight overall, not per bank
    assign slot_free = !pend_q || rsp_ready;

    assign itcm.req_valid = req_valid && slot_free && (sel == region_itcm);
    assign dtcm.req_valid = req_valid && slot_free && (sel == region_dtcm);
    assign itcm.req       = req;
    assign dtcm.req       = req;

    always_comb begin
        case (sel)
            region_itcm: sel_ready = itcm.req_ready;
            region_dtcm: sel_ready = dtcm.req_ready;
            default:     sel_ready = 1'b1;           // error slot is never busy on its own
        endcase
    end

    assign req_ready = slot_free && sel_ready;
    assign accept    = req_valid && req_ready;

    // ============================================================
    // ownership of the pending response
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q  <= 1'b0;
            owner_q <= region_none;
        end else if (accept) begin
            pend_q  <= 1'b1;
            owner_q <= sel;                          // new owner, old one taken
        end else if (rsp_ready) begin
            pend_q  <= 1'b0;
        end
    end

    assign err_valid = pend_q && (owner_q == region_none);

    // ============================================================
    // response mux
    // ============================================================

    assign itcm.rsp_ready = rsp_ready && (owner_q == region_itcm);
    assign dtcm.rsp_ready = rsp_ready && (owner_q == region_dtcm);

    always_comb begin
        case (owner_q)
            region_itcm: begin
                rsp_valid = itcm.rsp_valid;
                rsp       = itcm.rsp;
            end
            region_dtcm: begin
                rsp_valid = dtcm.rsp_valid;
                rsp       = dtcm.rsp;
            end
            default: begin
                rsp_valid = err_valid;               // no memory touched
                rsp.status = tcm_error;
                rsp.rdata  = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/tcm_bank_ctrl.sv ====
// TCM bank controller

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_bank_ctrl #(
    parameter int DEPTH = 512                        // words in this bank
) (
    input  wire logic clk,
    input  wire logic rst,
    tcm_req_if.bank   bus
);

    import tcm_bus_pkg::*;

    localparam int IW = $clog2(DEPTH);

    logic           pending;                         // response held for the decoder
    logic           was_read;                        // pending response carries data
    logic           accept;                          // request taken this edge
    logic           is_write;
    logic [IW-1:0]  index;
    logic [`TCM_DW-1:0] sram_rdata;

    // ============================================================
    // handshake
    // ============================================================

    assign bus.req_ready = !pending || bus.rsp_ready;    // free, or freed this edge
    assign accept        = bus.req_valid && bus.req_ready;
    assign is_write      = (bus.req.kind == tcm_write);
    assign index         = bus.req.addr[IW+1:2];     // word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;                         // also covers take-and-refill
        end else if (bus.rsp_ready) begin
            pending <= 1'b0;                         // response taken
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            was_read <= !is_write;
        end
    end

    // ============================================================
    // storage
    // ============================================================

    // no access while a response waits, so sram_rdata stays put
    tcm_sram #(
        .DEPTH (DEPTH),
        .MW    (`TCM_MW)
    ) sram0 (
        .clk   (clk),
        .en    (accept),
        .we    (is_write),
        .wmask (bus.req.wmask),
        .index (index),
        .wdata (bus.req.wdata),
        .rdata (sram_rdata)
    );

    // ============================================================
    // response
    // ============================================================

    assign bus.rsp_valid  = pending;
    assign bus.rsp.status = tcm_ok;                  // a mapped bank never fails
    assign bus.rsp.rdata  = was_read ? sram_rdata : '0;  // stores ack with zero

endmodule

`default_nettype wire

// ==== src/tcm_sram.sv ====
// Byte-lane synchronous SRAM

`timescale 1ns/1ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_sram #(
    parameter int DEPTH = 512,                       // words
    parameter int MW    = 4                          // byte lanes
) (
    input  wire logic                      clk,
    input  wire logic                      en,       // access strobe
    input  wire logic                      we,       // 1 store, 0 load
    input  wire logic [MW-1:0]             wmask,
    input  wire logic [$clog2(DEPTH)-1:0]  index,
    input  wire logic [`TCM_DW-1:0]        wdata,
    output logic      [`TCM_DW-1:0]        rdata
);

    localparam int IW = $clog2(DEPTH);
    localparam int DW = `TCM_DW;
    localparam int LW = DW / MW;                     // lane width, 8 for 32/4

    logic [IW-1:0] idx_r;                            // last read index

    // ============================================================
    // read port, output follows idx_r so it holds between loads
    // ============================================================

    always_ff @(posedge clk) begin
        if (en && !we) begin
            idx_r <= index;                          // only loads move the pointer
        end
    end

    // ============================================================
    // one narrow memory per byte lane
    // ============================================================

    genvar i;
    generate
        for (i = 0; i < MW; i = i + 1) begin : g_lane
            logic [LW-1:0] lane_mem [DEPTH];         // no reset, contents undefined

            always_ff @(posedge clk) begin
                if (en && we && wmask[i]) begin
                    lane_mem[index] <= wdata[LW*i +: LW];  // masked lane write
                end
            end

            assign rdata[LW*i +: LW] = lane_mem[idx_r];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/tcm_req_if.sv ====
// TCM bank channel interface

`timescale 1ns/1ps
`default_nettype none

interface tcm_req_if;

    import tcm_bus_pkg::*;

    // request, decoder to bank
    logic     req_valid;
    tcm_req_t req;
    logic     req_ready;                 // bank can take it

    // response, bank to decoder
    logic     rsp_valid;
    tcm_rsp_t rsp;
    logic     rsp_ready;                 // only set while the decoder owns this bank

    modport decoder (
        output req_valid,
        output req,
        input  req_ready,
        input  rsp_valid,
        input  rsp,
        output rsp_ready
    );

    modport bank (
        input  req_valid,
        input  req,
        output req_ready,
        output rsp_valid,
        output rsp,
        input  rsp_ready
    );

endinterface

`default_nettype wire

// ==== src/tcm_map_pkg.sv ====
// TCM address map types

`default_nettype none

`include "tcm_defs.svh"

package tcm_map_pkg;

    // which target owns an address
    typedef enum logic [1:0] {
        region_itcm = 2'd0,
        region_dtcm = 2'd1,
        region_none = 2'd2               // handled by the decoder error slot
    } tcm_region_e;

    // ============================================================
    // one address word, two ways to look at it
    // ============================================================

    typedef struct packed {
        logic [3:0]  region;             // top nibble picks the bank
        logic [16:0] unused;             // ignored by the map
        logic [8:0]  index;              // word within the bank
        logic [1:0]  offset;             // byte within word, lanes come from mask
    } tcm_addr_fields_t;

    typedef union packed {
        logic [`TCM_AW-1:0] raw;         // plain byte address
        tcm_addr_fields_t   fields;      // region/index/offset split
    } tcm_addr_u;

endpackage

`default_nettype wire

// ==== src/tcm_bus_pkg.sv ====
// TCM bus transfer types

`default_nettype none

`include "tcm_defs.svh"

package tcm_bus_pkg;

    // ============================================================
    // request channel
    // ============================================================

    typedef enum logic {
        tcm_read  = 1'b0,                // load from core
        tcm_write = 1'b1                 // store from core
    } tcm_kind_e;

    typedef struct packed {
        tcm_kind_e           kind;       // 1 bit
        logic [`TCM_AW-1:0]  addr;       // byte address, low bits ignored
        logic [`TCM_DW-1:0]  wdata;      // store data
        logic [`TCM_MW-1:0]  wmask;      // byte lanes to write
    } tcm_req_t;                         // 69 bits

    // ============================================================
    // response channel
    // ============================================================

    typedef enum logic {
        tcm_ok    = 1'b0,
        tcm_error = 1'b1                 // unmapped address
    } tcm_status_e;

    typedef struct packed {
        tcm_status_e         status;
        logic [`TCM_DW-1:0]  rdata;      // zero for stores and errors
    } tcm_rsp_t;                         // 33 bits

endpackage

`default_nettype wire

// ==== include/tcm_defs.svh ====
// TCM subsystem parameters

`ifndef TCM_DEFS_SVH
`define TCM_DEFS_SVH

// ============================================================
// bus widths
// ============================================================

`define TCM_DW 32                // data word
`define TCM_MW 4                 // one mask bit per byte lane
`define TCM_AW 32                // byte address

// ============================================================
// bank sizes, in words
// ============================================================

`define TCM_ITCM_DEPTH 512
`define TCM_DTCM_DEPTH 512

// ============================================================
// address map, top nibble of the byte address
// ============================================================

`define TCM_ITCM_REGION 4'h8     // 0x8xxx_xxxx
`define TCM_DTCM_REGION 4'h9     // 0x9xxx_xxxx

`endif
